/* design/cache_geom_pkg.sv */
// Cache geometry constants and address/data field types, imported by every cache module
`default_nettype none

package cache_geom_pkg;

    // --------------------------------------------------
    // Geometry
    // --------------------------------------------------
    localparam int WORD_W         = 32;
    localparam int LINE_W         = 128;
    localparam int WORDS_PER_LINE = LINE_W / WORD_W;      // 4 words per line
    localparam int NUM_SETS       = 4;
    localparam int NUM_WAYS       = 2;

    // Processor side uses word addresses
    localparam int ADDR_W      = 30;
    localparam int OFF_W       = $clog2(WORDS_PER_LINE);
    localparam int SET_W       = $clog2(NUM_SETS);
    localparam int LINE_ADDR_W = ADDR_W - OFF_W;          // Memory line address
    localparam int TAG_W       = LINE_ADDR_W - SET_W;

    // --------------------------------------------------
    // Field types
    // --------------------------------------------------
    typedef logic [WORD_W-1:0] word_t;

    // Word k sits in slice k
    typedef word_t [WORDS_PER_LINE-1:0] line_t;

    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [SET_W-1:0] set_idx_t;
    typedef logic [OFF_W-1:0] word_off_t;

    // Word address, high to low
    typedef struct packed {
        tag_t      tag;
        set_idx_t  set;
        word_off_t off;
    } word_addr_t;

    // Line address as seen by the slow memory
    typedef struct packed {
        tag_t     tag;
        set_idx_t set;
    } line_addr_t;

endpackage

`default_nettype wire

/* design/cache_bus_pkg.sv */
// Processor and memory bus structs plus the miss controller state, shared by the cache modules
`default_nettype none

package cache_bus_pkg;

    import cache_geom_pkg::*;

    // --------------------------------------------------
    // Processor side
    // --------------------------------------------------
    typedef struct packed {
        logic       read;
        logic       write;
        word_addr_t addr;
        word_t      wdata;
    } proc_req_t;

    // --------------------------------------------------
    // Memory side
    // --------------------------------------------------
    typedef struct packed {
        logic       read;
        logic       write;
        line_addr_t addr;
        line_t      wdata;
    } mem_req_t;

    typedef struct packed {
        line_t rdata;
        logic  ready;       // One-cycle pulse
    } mem_rsp_t;

    // Replacement candidate of the addressed set, plus the tag being asked for
    typedef struct packed {
        logic       dirty;
        line_addr_t addr;
        line_t      data;
        tag_t       req_tag;
    } victim_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EVICT,   // Writing back a dirty victim
        ST_FILL     // Reading the missing line
    } cache_state_t;

endpackage

`default_nettype wire

/* design/cache_store.sv */
// Two-way cache arrays with hit detection, read mux, write hits, fill and victim selection
`timescale 1ns/1ns
`default_nettype none

module cache_store
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  proc_req_t proc_req,
    input  logic      fill,
    input  line_t     fill_line,
    output word_t     proc_rdata,
    output logic      miss,
    output victim_t   victim
);

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------
    tag_t  tag_q  [NUM_WAYS][NUM_SETS];
    line_t data_q [NUM_WAYS][NUM_SETS];

    logic [NUM_WAYS-1:0][NUM_SETS-1:0] valid_q;
    logic [NUM_WAYS-1:0][NUM_SETS-1:0] dirty_q;
    logic [NUM_SETS-1:0]               lru_q;      // Way to replace next

    set_idx_t            set_idx;
    logic                req_valid;
    logic [NUM_WAYS-1:0] way_hit;
    logic                any_hit;
    logic                hit_way;
    logic                vict_way;

    assign set_idx   = proc_req.addr.set;
    assign req_valid = proc_req.read | proc_req.write;
    assign vict_way  = lru_q[set_idx];

    // --------------------------------------------------
    // Hit logic
    // --------------------------------------------------
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = valid_q[w][set_idx] && (tag_q[w][set_idx] == proc_req.addr.tag);
        end
    end

    assign any_hit = |way_hit;
    assign hit_way = way_hit[1];    // Only meaningful with any_hit

    // Stall the processor until the line is resident
    assign miss = req_valid && !any_hit;

    assign proc_rdata = (proc_req.read && any_hit)
                      ? data_q[hit_way][set_idx][proc_req.addr.off]
                      : '0;

    // --------------------------------------------------
    // Victim of the addressed set
    // --------------------------------------------------
    always_comb begin
        victim.dirty    = dirty_q[vict_way][set_idx];
        victim.addr.tag = tag_q[vict_way][set_idx];
        victim.addr.set = set_idx;
        victim.data     = data_q[vict_way][set_idx];
        victim.req_tag  = proc_req.addr.tag;    // Lets the controller form the refill address
    end

    // --------------------------------------------------
    // Control bits
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else if (fill) begin
            // New line always arrives clean
            valid_q[vict_way][set_idx] <= 1'b1;
            dirty_q[vict_way][set_idx] <= 1'b0;
        end else if (req_valid && any_hit) begin
            lru_q[set_idx] <= ~hit_way;     // Point away from the used way
            if (proc_req.write) begin
                dirty_q[hit_way][set_idx] <= 1'b1;
            end
        end
    end

    // Tags and line data
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[vict_way][set_idx]  <= proc_req.addr.tag;
            data_q[vict_way][set_idx] <= fill_line;
        end else if (proc_req.write && any_hit) begin
            data_q[hit_way][set_idx][proc_req.addr.off] <= proc_req.wdata;
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    // A fill must never duplicate a line that is already resident
    a_single_hit: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(way_hit[0] && way_hit[1])
    ) else $error("cache_store: both ways hit in set %0d", set_idx);

    // Processor has to hold its request through the whole miss
    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        miss |=> $stable(proc_req)
    ) else $error("cache_store: request changed during a miss");

endmodule

`default_nettype wire

/* design/miss_fsm.sv */
// Miss controller that writes back a dirty victim and refills the missing line from memory
`timescale 1ns/1ns
`default_nettype none

module miss_fsm
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     miss,
    input  victim_t  victim,
    input  mem_rsp_t mem_rsp,
    output mem_req_t mem_req,
    output logic     fill,
    output line_t    fill_line
);

    // --------------------------------------------------
    // State and registered memory request
    // --------------------------------------------------
    cache_state_t state_q;
    cache_state_t state_d;
    mem_req_t     req_q;
    mem_req_t     req_d;
    line_addr_t   miss_addr_q;      // Line being refilled
    line_addr_t   miss_addr_d;

    always_comb begin
        state_d     = state_q;
        req_d       = req_q;
        miss_addr_d = miss_addr_q;
        fill        = 1'b0;

        case (state_q)
            ST_IDLE: begin
                if (miss) begin
                    miss_addr_d.tag = victim.req_tag;
                    miss_addr_d.set = victim.addr.set;
                    if (victim.dirty) begin
                        // Write the old line out first
                        state_d     = ST_EVICT;
                        req_d.read  = 1'b0;
                        req_d.write = 1'b1;
                        req_d.addr  = victim.addr;
                        req_d.wdata = victim.data;
                    end else begin
                        state_d     = ST_FILL;
                        req_d.read  = 1'b1;
                        req_d.write = 1'b0;
                        req_d.addr  = miss_addr_d;
                    end
                end
            end

            ST_EVICT: begin
                if (mem_rsp.ready) begin
                    state_d     = ST_FILL;
                    req_d.write = 1'b0;
                    req_d.read  = 1'b1;
                    req_d.addr  = miss_addr_q;
                end
            end

            ST_FILL: begin
                if (mem_rsp.ready) begin
                    fill       = 1'b1;      // Store installs at this edge
                    req_d.read = 1'b0;
                    state_d    = ST_IDLE;
                end
            end

            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= ST_IDLE;
            req_q.read  <= 1'b0;
            req_q.write <= 1'b0;
        end else begin
            state_q     <= state_d;
            req_q.read  <= req_d.read;
            req_q.write <= req_d.write;
        end
    end

    // Address and line payload
    always_ff @(posedge clk) begin
        req_q.addr  <= req_d.addr;
        req_q.wdata <= req_d.wdata;
        miss_addr_q <= miss_addr_d;
    end

    assign mem_req   = req_q;
    assign fill_line = mem_rsp.rdata;   // Valid in the ready cycle

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    a_one_dir: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(mem_req.read && mem_req.write)
    ) else $error("miss_fsm: memory read and write both high");

    // Fill lands only in a refill whose request still misses
    a_fill_in_fill: assert property (
        @(posedge clk) disable iff (!rst_n)
        fill |-> (state_q == ST_FILL) && miss
    ) else $error("miss_fsm: fill outside of refill");

endmodule

`default_nettype wire

/* design/data_cache.sv */
// Top level of the write-back data cache, joining the arrays and the miss controller
`timescale 1ns/1ns
`default_nettype none

module data_cache
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // Processor side
    input  proc_req_t proc_req,
    output word_t     proc_rdata,
    output logic      stall,

    // Slow memory side
    output mem_req_t  mem_req,
    input  mem_rsp_t  mem_rsp
);

    // --------------------------------------------------
    // Internal wires
    // --------------------------------------------------
    logic    fill;          // One-cycle install strobe
    line_t   fill_line;
    victim_t victim;

    // Arrays and hit logic; its miss is the processor stall
    cache_store cache_store_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .proc_req   (proc_req),
        .fill       (fill),
        .fill_line  (fill_line),
        .proc_rdata (proc_rdata),
        .miss       (stall),
        .victim     (victim)
    );

    // Write-back and refill sequencing
    miss_fsm miss_fsm_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .miss       (stall),
        .victim     (victim),
        .mem_rsp    (mem_rsp),
        .mem_req    (mem_req),
        .fill       (fill),
        .fill_line  (fill_line)
    );

endmodule

`default_nettype wire

/* tb/slow_mem_model.sv */
// Behavioral line memory for the cache testbench, answers each request after a fixed latency
`timescale 1ns/1ns
`default_nettype none

module slow_mem_model
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;
#(
    parameter int LATENCY = 3
) (
    input  logic     clk,
    input  logic     rst_n,
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp
);

    localparam int DEPTH = 256;     // Lines, covers word addresses 0 to 1023

    line_t                  mem [DEPTH];
    logic                   busy;
    int                     count;
    logic [7:0]             cur_idx;
    logic [LINE_ADDR_W-1:0] req_line;

    assign req_line = mem_req.addr;

    // Every word holds its own word address
    initial begin
        for (int l = 0; l < DEPTH; l++) begin
            for (int k = 0; k < WORDS_PER_LINE; k++) begin
                mem[l][k] = word_t'(l * WORDS_PER_LINE + k);
            end
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            count   <= 0;
            mem_rsp <= '0;
        end else begin
            mem_rsp.ready <= 1'b0;
            if (mem_rsp.ready) begin
                busy <= 1'b0;       // Request seen at this edge is the one just answered
            end else if (!busy && (mem_req.read || mem_req.write)) begin
                busy    <= 1'b1;
                count   <= 1;
                cur_idx <= req_line[7:0];
                if (mem_req.write) begin
                    mem[req_line[7:0]] <= mem_req.wdata;
                end
            end else if (busy) begin
                if (count == LATENCY - 1) begin
                    mem_rsp.ready <= 1'b1;
                    mem_rsp.rdata <= mem[cur_idx];
                end else begin
                    count <= count + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb/cache_checker.sv */
// Watches the cache ports, tracks a shadow word memory and compares every completed access
`timescale 1ns/1ns
`default_nettype none

module cache_checker
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  proc_req_t  proc_req,
    input  word_t      proc_rdata,
    input  logic       stall,
    input  mem_req_t   mem_req,
    input  mem_rsp_t   mem_rsp,
    input  logic       exp_wb,       // Write-back expected during this access
    input  logic       exp_rd,       // Refill expected during this access
    input  line_addr_t exp_wb_addr,
    output int         check_count,
    output int         error_count
);

    localparam int SHADOW_WORDS = 1024;

    word_t             shadow [SHADOW_WORDS];
    int                wb_seen;
    int                rd_seen;
    logic [ADDR_W-1:0] req_word;
    line_addr_t        req_line;

    assign req_word = proc_req.addr;
    assign req_line = {proc_req.addr.tag, proc_req.addr.set};

    initial begin
        check_count = 0;
        error_count = 0;
        wb_seen     = 0;
        rd_seen     = 0;
        for (int i = 0; i < SHADOW_WORDS; i++) begin
            shadow[i] = word_t'(i);
        end
    end

    task automatic compare(input string name, input logic [LINE_W-1:0] expected,
                           input logic [LINE_W-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    function automatic line_t shadow_line(input line_addr_t la);
        line_t                  l;
        logic [LINE_ADDR_W-1:0] v;
        v = la;
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
            l[k] = shadow[int'(v[7:0]) * WORDS_PER_LINE + k];
        end
        return l;
    endfunction

    always @(posedge clk) begin
        if (rst_n) begin
            // --------------------------------------------------
            // Quiet bus with no request
            // --------------------------------------------------
            if (!(proc_req.read || proc_req.write)) begin
                compare("stall", 1'b0, stall);
                compare("mem_req.read", 1'b0, mem_req.read);
                compare("mem_req.write", 1'b0, mem_req.write);
            end

            if (mem_rsp.ready && mem_req.write) begin
                wb_seen++;
                compare("mem_req.addr (write-back)", exp_wb_addr, mem_req.addr);
                compare("mem_req.wdata", shadow_line(mem_req.addr), mem_req.wdata);
            end
            if (mem_rsp.ready && mem_req.read) begin
                rd_seen++;
                compare("mem_req.addr (refill)", req_line, mem_req.addr);
                if (exp_wb && wb_seen == 0) begin
                    error_count++;
                    $display("Refill read at %0t ns came before the expected write-back", $time);
                end
            end

            // Access completes at the first edge without stall
            if ((proc_req.read || proc_req.write) && !stall) begin
                if (req_word >= SHADOW_WORDS) begin
                    error_count++;
                    $display("Request address %0h is outside the checked range", req_word);
                end else if (proc_req.read) begin
                    compare("proc_rdata", shadow[req_word], proc_rdata);
                end else begin
                    shadow[req_word] = proc_req.wdata;
                end
                compare("write-back count", exp_wb, wb_seen);
                compare("refill count", exp_rd, rd_seen);
                wb_seen = 0;
                rd_seen = 0;
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_data_cache.sv */
// Top testbench for the data cache, applies the access table and prints the final result
`timescale 1ns/1ns
`default_nettype none

module tb_data_cache
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;
();

    localparam int MEM_LAT         = 3;
    localparam int NUM_STEPS       = 25;
    localparam int WATCHDOG_CYCLES = NUM_STEPS * 2 * (MEM_LAT + 4) + 20;

    typedef enum logic {OP_READ, OP_WRITE} op_t;

    typedef struct packed {
        op_t        op;
        word_addr_t addr;
        logic       rand_data;
        logic       exp_wb;
        logic       exp_rd;
        line_addr_t wb_line;
    } step_t;

    logic       clk = 1'b0;
    logic       rst_n;
    proc_req_t  proc_req;
    word_t      proc_rdata;
    logic       stall;
    mem_req_t   mem_req;
    mem_rsp_t   mem_rsp;
    logic       exp_wb;
    logic       exp_rd;
    line_addr_t exp_wb_addr;
    int         check_count;
    int         error_count;
    int         seed;
    step_t      steps [NUM_STEPS];
    int         num_loaded;

    always #4 clk = ~clk;

    data_cache data_cache_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .proc_req   (proc_req),
        .proc_rdata (proc_rdata),
        .stall      (stall),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

    slow_mem_model #(.LATENCY(MEM_LAT)) slow_mem_model_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    cache_checker cache_checker_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .proc_req    (proc_req),
        .proc_rdata  (proc_rdata),
        .stall       (stall),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp),
        .exp_wb      (exp_wb),
        .exp_rd      (exp_rd),
        .exp_wb_addr (exp_wb_addr),
        .check_count (check_count),
        .error_count (error_count)
    );

    task automatic add_step(input op_t op, input logic [ADDR_W-1:0] addr, input logic rnd,
                            input logic wb, input logic rd, input logic [LINE_ADDR_W-1:0] wb_line);
        steps[num_loaded].op        = op;
        steps[num_loaded].addr      = addr;
        steps[num_loaded].rand_data = rnd;
        steps[num_loaded].exp_wb    = wb;
        steps[num_loaded].exp_rd    = rd;
        steps[num_loaded].wb_line   = wb_line;
        num_loaded++;
    endtask

    // --------------------------------------------------
    // Access table: op, word address, random data, write-back, refill, victim line
    // --------------------------------------------------
    task automatic build_table();
        num_loaded = 0;
        add_step(OP_READ,  30'h014, 1'b0, 1'b0, 1'b1, 28'h0);  // Set 1 tag A, clean miss
        add_step(OP_READ,  30'h017, 1'b0, 1'b0, 1'b0, 28'h0);
        add_step(OP_WRITE, 30'h015, 1'b1, 1'b0, 1'b0, 28'h0);  // Write hit, A dirty
        add_step(OP_READ,  30'h015, 1'b0, 1'b0, 1'b0, 28'h0);
        add_step(OP_WRITE, 30'h026, 1'b1, 1'b0, 1'b1, 28'h0);  // Tag B into way 1
        add_step(OP_READ,  30'h014, 1'b0, 1'b0, 1'b0, 28'h0);  // A again, LRU points at B
        add_step(OP_WRITE, 30'h034, 1'b1, 1'b1, 1'b1, 28'h9);  // Tag C evicts dirty B
        add_step(OP_READ,  30'h017, 1'b0, 1'b0, 1'b0, 28'h0);  // A must still hit
        add_step(OP_READ,  30'h036, 1'b0, 1'b0, 1'b0, 28'h0);
        add_step(OP_READ,  30'h044, 1'b0, 1'b1, 1'b1, 28'h5);  // Tag D evicts dirty A
        add_step(OP_READ,  30'h026, 1'b0, 1'b1, 1'b1, 28'hd);  // B comes back from memory
        add_step(OP_READ,  30'h015, 1'b0, 1'b0, 1'b1, 28'h0);  // D is clean
        add_step(OP_READ,  30'h008, 1'b0, 1'b0, 1'b1, 28'h0);
        add_step(OP_READ,  30'h018, 1'b0, 1'b0, 1'b1, 28'h0);
        add_step(OP_READ,  30'h028, 1'b0, 1'b0, 1'b1, 28'h0);  // Clean replacement in set 2
        add_step(OP_READ,  30'h00b, 1'b0, 1'b0, 1'b1, 28'h0);
        add_step(OP_WRITE, 30'h000, 1'b1, 1'b0, 1'b1, 28'h0);
        add_step(OP_WRITE, 30'h003, 1'b0, 1'b0, 1'b0, 28'h0);  // Fixed zero data
        add_step(OP_READ,  30'h000, 1'b0, 1'b0, 1'b0, 28'h0);
        add_step(OP_READ,  30'h003, 1'b0, 1'b0, 1'b0, 28'h0);
        add_step(OP_WRITE, 30'h03f, 1'b1, 1'b0, 1'b1, 28'h0);
        add_step(OP_READ,  30'h03c, 1'b0, 1'b0, 1'b0, 28'h0);
        add_step(OP_READ,  30'h010, 1'b0, 1'b0, 1'b1, 28'h0);
        add_step(OP_READ,  30'h020, 1'b0, 1'b1, 1'b1, 28'h0);  // Set 0 line 0 written back
        add_step(OP_READ,  30'h003, 1'b0, 1'b0, 1'b1, 28'h0);
    endtask

    // Holds one request until an edge without stall, then one idle cycle
    task automatic run_step(input step_t s);
        logic done;
        @(posedge clk);
        #1;
        proc_req.read  = (s.op == OP_READ);
        proc_req.write = (s.op == OP_WRITE);
        proc_req.addr  = s.addr;
        proc_req.wdata = s.rand_data ? word_t'($random(seed)) : '0;
        exp_wb         = s.exp_wb;
        exp_rd         = s.exp_rd;
        exp_wb_addr    = s.wb_line;
        done           = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = !stall;      // Same value as at the coming rising edge
        end
        @(posedge clk);
        #1;
        proc_req = '0;
        exp_wb   = 1'b0;
        exp_rd   = 1'b0;
    endtask

    task automatic print_summary();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
    endtask

    initial begin
        seed        = 32'h6b64_a6b2;
        rst_n       = 1'b0;
        proc_req    = '0;
        exp_wb      = 1'b0;
        exp_rd      = 1'b0;
        exp_wb_addr = '0;
        build_table();
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (3) @(posedge clk);  // Idle cycles after reset
        for (int i = 0; i < NUM_STEPS; i++) begin
            run_step(steps[i]);
        end
        @(posedge clk);
        print_summary();
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the access table did not finish within %0d cycles", WATCHDOG_CYCLES);
        print_summary();
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
design/cache_geom_pkg.sv
design/cache_bus_pkg.sv
design/cache_store.sv
design/miss_fsm.sv
design/data_cache.sv
tb/slow_mem_model.sv
tb/cache_checker.sv
tb/tb_data_cache.sv
